/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;
  typedef logic [7:0]  uart_byte_t;
  typedef logic [3:0]  reg_off_t;    // register offset within the uart map
  typedef logic [2:0]  bit_cnt_t;    // data bit index 0..7

  localparam axil_resp_t resp_okay   = 2'b00;
  localparam axil_resp_t resp_slverr = 2'b10;

  // uart register map, decoded on addr[3:0]
  localparam reg_off_t reg_rx_fifo = 4'h0;
  localparam reg_off_t reg_tx_fifo = 4'h4;
  localparam reg_off_t reg_stat    = 4'h8;
  localparam reg_off_t reg_ctrl    = 4'hc;

  // status word bits
  localparam int stat_rx_valid = 0;
  localparam int stat_tx_empty = 2;
  localparam int stat_tx_full  = 3;
  localparam int stat_overrun  = 5;

  // control word bits
  localparam int ctrl_rst_tx = 0;
  localparam int ctrl_rst_rx = 1;

  localparam int clks_per_bit = 8;    // serial bit period in clocks
  typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;

  typedef struct packed {
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
  } axil_wr_req_t;

  typedef struct packed {
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    logic       valid;    // shared by aw and w
  } axil_aw_w_t;

  typedef struct packed {
    axil_addr_t addr;
    logic       valid;
  } axil_ar_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
    logic       valid;
  } axil_r_t;

  typedef struct packed {
    axil_resp_t resp;
    logic       valid;
  } axil_b_t;

endpackage

`default_nettype wire

/* axil_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_master (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start_read,
  input  logic                   start_write,
  input  soc_pkg::axil_wr_req_t  wr_req,
  input  soc_pkg::axil_addr_t    rd_addr,
  input  logic                   aw_w_ready,
  input  logic                   ar_ready,
  input  soc_pkg::axil_r_t       r,
  input  soc_pkg::axil_b_t       b,
  output logic                   done_read,
  output logic                   done_write,
  output logic                   busy_read,
  output logic                   busy_write,
  output soc_pkg::axil_data_t    rd_data,
  output logic                   error,
  output soc_pkg::axil_aw_w_t    aw_w,
  output soc_pkg::axil_ar_t      ar,
  output logic                   r_ready,
  output logic                   b_ready
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    ch_idle,
    ch_addr,
    ch_resp
  } ch_state_e;

  ch_state_e wr_state;
  ch_state_e rd_state;

  assign busy_write = (wr_state != ch_idle) || done_write;  // covers the done cycle
  assign busy_read  = (rd_state != ch_idle) || done_read;
  assign b_ready    = wr_state != ch_idle;
  assign r_ready    = rd_state != ch_idle;

  // write channel, aw and w go out together
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state   <= ch_idle;
      aw_w       <= '0;
      done_write <= 1'b0;
    end else begin
      done_write <= 1'b0;
      case (wr_state)
        ch_idle: begin
          if (start_write) begin
            aw_w.addr  <= wr_req.addr;
            aw_w.data  <= wr_req.data;
            aw_w.strb  <= wr_req.strb;
            aw_w.valid <= 1'b1;
            wr_state   <= ch_addr;
          end
        end
        ch_addr: begin
          if (aw_w_ready) begin
            aw_w.valid <= 1'b0;
            wr_state   <= ch_resp;
          end
        end
        ch_resp: begin
          if (b.valid) begin  // b_ready is high here
            done_write <= 1'b1;
            wr_state   <= ch_idle;
          end
        end
        default: wr_state <= ch_idle;
      endcase
    end
  end

  // read channel
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state  <= ch_idle;
      ar        <= '0;
      done_read <= 1'b0;
    end else begin
      done_read <= 1'b0;
      case (rd_state)
        ch_idle: begin
          if (start_read) begin
            ar.addr  <= rd_addr;
            ar.valid <= 1'b1;
            rd_state <= ch_addr;
          end
        end
        ch_addr: begin
          if (ar_ready) begin
            ar.valid <= 1'b0;
            rd_state <= ch_resp;
          end
        end
        ch_resp: begin
          if (r.valid) begin
            done_read <= 1'b1;
            rd_state  <= ch_idle;
          end
        end
        default: rd_state <= ch_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_state == ch_resp && r.valid) rd_data <= r.data;  // held until next read
  end

  // sticky until the next start of either channel
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      error <= 1'b0;
    end else begin
      if (start_read || start_write) error <= 1'b0;
      if (wr_state == ch_resp && b.valid && b.resp != resp_okay) error <= 1'b1;
      if (rd_state == ch_resp && r.valid && r.resp != resp_okay) error <= 1'b1;
    end
  end

  a_no_start_wr_busy: assert property (@(posedge clk) disable iff (!arst_n)
    start_write |-> !busy_write);
  a_no_start_rd_busy: assert property (@(posedge clk) disable iff (!arst_n)
    start_read |-> !busy_read);
  a_aw_w_stable: assert property (@(posedge clk) disable iff (!arst_n)
    aw_w.valid && !aw_w_ready |=> aw_w.valid && $stable(aw_w));
  a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
    ar.valid && !ar_ready |=> ar.valid && $stable(ar));

endmodule

`default_nettype wire

/* uart_lite_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_lite_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  soc_pkg::axil_aw_w_t  aw_w,
  input  soc_pkg::axil_ar_t    ar,
  input  logic                 r_ready,
  input  logic                 b_ready,
  input  logic                 tx_busy,
  input  logic                 rx_strobe,
  input  soc_pkg::uart_byte_t  rx_byte,
  output logic                 aw_w_ready,
  output logic                 ar_ready,
  output soc_pkg::axil_r_t     r,
  output soc_pkg::axil_b_t     b,
  output logic                 tx_start,
  output soc_pkg::uart_byte_t  tx_byte
);
  import soc_pkg::*;

  logic       wr_fire;
  logic       rd_fire;
  logic       wr_bad;
  logic       rd_bad;
  logic       wr_en;
  logic       tx_load;
  reg_off_t   wr_off;
  reg_off_t   rd_off;
  uart_byte_t tx_hold;
  uart_byte_t rx_hold;
  logic       tx_full;
  logic       rx_valid;
  logic       overrun;
  axil_data_t stat_word;
  axil_data_t rd_word;

  // outside the map or not word aligned
  function automatic logic addr_bad(input axil_addr_t addr);
    return (|addr[31:4]) || (|addr[1:0]);
  endfunction

  assign aw_w_ready = !b.valid || b_ready;
  assign wr_fire    = aw_w.valid && aw_w_ready;
  assign ar_ready   = (!r.valid || r_ready) && !wr_fire;  // write wins a tie
  assign rd_fire    = ar.valid && ar_ready;

  assign wr_off  = aw_w.addr[3:0];
  assign rd_off  = ar.addr[3:0];
  assign wr_bad  = addr_bad(aw_w.addr);
  assign rd_bad  = addr_bad(ar.addr);
  assign wr_en   = wr_fire && !wr_bad && aw_w.strb[0];  // all fields sit in byte 0
  assign tx_load = wr_en && wr_off == reg_tx_fifo && !tx_full && !tx_busy;

  assign tx_start = tx_full && !tx_busy;
  assign tx_byte  = tx_hold;

  always_comb begin
    stat_word                = '0;
    stat_word[stat_rx_valid] = rx_valid;
    stat_word[stat_tx_empty] = !tx_full && !tx_busy;
    stat_word[stat_tx_full]  = tx_full;
    stat_word[stat_overrun]  = overrun;
  end

  always_comb begin
    rd_word = '0;
    if (!rd_bad) begin
      case (rd_off)
        reg_rx_fifo: if (rx_valid) rd_word = axil_data_t'(rx_hold);
        reg_stat:    rd_word = stat_word;
        default:     rd_word = '0;  // tx and ctrl read back zero
      endcase
    end
  end

  // response channels
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      b <= '0;
      r <= '0;
    end else begin
      if (wr_fire) begin
        b.valid <= 1'b1;
        b.resp  <= wr_bad ? resp_slverr : resp_okay;
      end else if (b_ready) begin
        b.valid <= 1'b0;
      end
      if (rd_fire) begin
        r.valid <= 1'b1;
        r.resp  <= rd_bad ? resp_slverr : resp_okay;
        r.data  <= rd_word;
      end else if (r_ready) begin
        r.valid <= 1'b0;
      end
    end
  end

  // holding register flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_full  <= 1'b0;
      rx_valid <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      if (tx_start) tx_full <= 1'b0;
      if (tx_load) tx_full <= 1'b1;  // full or busy drops the byte
      if (wr_en && wr_off == reg_ctrl) begin
        if (aw_w.data[ctrl_rst_tx]) tx_full <= 1'b0;
        if (aw_w.data[ctrl_rst_rx]) rx_valid <= 1'b0;
      end
      if (rd_fire && !rd_bad) begin
        if (rd_off == reg_rx_fifo) rx_valid <= 1'b0;
        if (rd_off == reg_stat) overrun <= 1'b0;
      end
      if (rx_strobe) begin
        if (rx_valid) overrun <= 1'b1;  // keep the first byte
        else rx_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) tx_hold <= aw_w.data[7:0];
    if (rx_strobe && !rx_valid) rx_hold <= rx_byte;
  end

  // the serializer must take every launch
  a_tx_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
    tx_start |=> tx_busy);

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 tx_start,
  input  soc_pkg::uart_byte_t  tx_byte,
  output logic                 tx_busy,
  output logic                 tx
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_e;

  tx_state_e  state;
  baud_cnt_t  baud_cnt;
  bit_cnt_t   bit_cnt;
  uart_byte_t shreg;
  logic       bit_end;

  assign bit_end = baud_cnt == baud_cnt_t'(clks_per_bit - 1);
  assign tx_busy = state != st_idle;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;  // line idles high
    end else begin
      baud_cnt <= (state == st_idle || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        st_idle: begin
          if (tx_start) begin
            state <= st_start;
            tx    <= 1'b0;
          end
        end
        st_start: begin
          if (bit_end) begin
            state   <= st_data;
            tx      <= shreg[0];  // lsb first
            bit_cnt <= '0;
          end
        end
        st_data: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
              tx    <= 1'b1;
            end else begin
              tx      <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        st_stop: if (bit_end) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && tx_start) shreg <= tx_byte;
    else if ((state == st_start || state == st_data) && bit_end) shreg <= shreg >> 1;
  end

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 rx,
  output logic                 rx_strobe,
  output soc_pkg::uart_byte_t  rx_byte
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_e;

  rx_state_e  state;
  baud_cnt_t  baud_cnt;
  bit_cnt_t   bit_cnt;
  uart_byte_t shreg;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       rx_fall;
  logic       half_hit;
  logic       bit_end;

  assign rx_fall  = rx_prev && !rx_sync;
  assign half_hit = state == st_start && baud_cnt == baud_cnt_t'(clks_per_bit / 2 - 1);
  assign bit_end  = baud_cnt == baud_cnt_t'(clks_per_bit - 1);

  // two flop synchronizer plus edge history
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      baud_cnt  <= (state == st_idle || half_hit || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        st_idle: if (rx_fall) state <= st_start;
        st_start: begin
          if (half_hit) begin
            state   <= rx_sync ? st_idle : st_data;  // glitch, not a start bit
            bit_cnt <= '0;
          end
        end
        st_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= st_stop;
          end
        end
        st_stop: begin
          if (bit_end) begin
            state     <= st_idle;
            rx_strobe <= rx_sync;  // framing error drops the byte
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_data && bit_end) shreg <= {rx_sync, shreg[7:1]};
    if (state == st_stop && bit_end && rx_sync) rx_byte <= shreg;
  end

endmodule

`default_nettype wire

/* soc_periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_periph_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   rx,
  input  logic                   start_read,
  input  logic                   start_write,
  input  soc_pkg::axil_wr_req_t  wr_req,
  input  soc_pkg::axil_addr_t    rd_addr,
  output logic                   tx,
  output logic                   done_read,
  output logic                   done_write,
  output logic                   busy_read,
  output logic                   busy_write,
  output soc_pkg::axil_data_t    rd_data,
  output logic                   error
);
  import soc_pkg::*;

  axil_aw_w_t aw_w;
  axil_ar_t   ar;
  axil_r_t    r;
  axil_b_t    b;
  logic       aw_w_ready;
  logic       ar_ready;
  logic       r_ready;
  logic       b_ready;
  logic       tx_start;
  logic       tx_busy;
  uart_byte_t tx_byte;
  logic       rx_strobe;
  uart_byte_t rx_byte;

  axil_master i_axil_master (
    .clk         (clk),
    .arst_n      (arst_n),
    .start_read  (start_read),
    .start_write (start_write),
    .wr_req      (wr_req),
    .rd_addr     (rd_addr),
    .aw_w_ready  (aw_w_ready),
    .ar_ready    (ar_ready),
    .r           (r),
    .b           (b),
    .done_read   (done_read),
    .done_write  (done_write),
    .busy_read   (busy_read),
    .busy_write  (busy_write),
    .rd_data     (rd_data),
    .error       (error),
    .aw_w        (aw_w),
    .ar          (ar),
    .r_ready     (r_ready),
    .b_ready     (b_ready)
  );

  uart_lite_regs i_uart_lite_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .aw_w       (aw_w),
    .ar         (ar),
    .r_ready    (r_ready),
    .b_ready    (b_ready),
    .tx_busy    (tx_busy),
    .rx_strobe  (rx_strobe),
    .rx_byte    (rx_byte),
    .aw_w_ready (aw_w_ready),
    .ar_ready   (ar_ready),
    .r          (r),
    .b          (b),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte)
  );

  uart_tx i_uart_tx (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)         // serial out pin
  );

  uart_rx i_uart_rx (
    .clk       (clk),
    .arst_n    (arst_n),
    .rx        (rx),        // serial in pin
    .rx_strobe (rx_strobe),
    .rx_byte   (rx_byte)
  );

endmodule

`default_nettype wire

/* soc_periph_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_periph_tb;
  import soc_pkg::*;

  typedef struct packed {
    logic       tx_idle;   // holding register and serializer both empty
    logic       rx_valid;
    uart_byte_t rx_byte;
    logic       overrun;
  } uart_model_t;

  typedef struct packed {
    logic       err;
    axil_data_t data;
  } reg_resp_t;

  localparam int frame_clks  = 10 * clks_per_bit;
  localparam int cycle_limit = 12 * frame_clks + 2000;
  localparam int latency     = 3;  // start sample to done, idle slave

  localparam axil_addr_t rx_addr   = {28'h0, reg_rx_fifo};
  localparam axil_addr_t tx_addr   = {28'h0, reg_tx_fifo};
  localparam axil_addr_t stat_addr = {28'h0, reg_stat};
  localparam axil_addr_t ctrl_addr = {28'h0, reg_ctrl};

  logic         clk;
  logic         arst_n;
  logic         start_read;
  logic         start_write;
  axil_wr_req_t wr_req;
  axil_addr_t   rd_addr;
  logic         done_read;
  logic         done_write;
  logic         busy_read;
  logic         busy_write;
  axil_data_t   rd_data;
  logic         error;
  wire          serial_line;  // tx looped back into rx

  uart_model_t  model;
  uart_byte_t   tx_seen[$];   // bytes decoded from the tx pin
  uart_byte_t   byte_a;
  uart_byte_t   byte_b;
  uart_byte_t   byte_c;
  int           seed_val;
  int           cycle_cnt = 0;

  soc_periph_top i_soc_periph_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .rx          (serial_line),
    .start_read  (start_read),
    .start_write (start_write),
    .wr_req      (wr_req),
    .rd_addr     (rd_addr),
    .tx          (serial_line),
    .done_read   (done_read),
    .done_write  (done_write),
    .busy_read   (busy_read),
    .busy_write  (busy_write),
    .rd_data     (rd_data),
    .error       (error)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) abort_run("timeout, the test did not finish in time");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      abort_run($sformatf("mismatch at %0t: %s expected 0x%0h actual 0x%0h",
                          $time, name, exp_val, act_val));
    end
  endtask

  // expected read data and error from the register map rules
  function automatic reg_resp_t expect_reg(input axil_addr_t addr, input uart_model_t m);
    reg_resp_t res;
    res = '0;
    if (addr[31:4] != '0) begin
      res.err = 1'b1;  // outside the map, data stays 0
    end else if (addr[3:0] == reg_rx_fifo) begin
      if (m.rx_valid) res.data = {24'h0, m.rx_byte};
    end else if (addr[3:0] == reg_stat) begin
      res.data[stat_rx_valid] = m.rx_valid;
      res.data[stat_tx_empty] = m.tx_idle;
      res.data[stat_overrun]  = m.overrun;
      // tx_full only lasts one cycle when the serializer is idle
    end
    return res;
  endfunction

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data, output logic err);
    int lat;
    @(posedge clk);
    wr_req.addr <= addr;
    wr_req.data <= data;
    wr_req.strb <= 4'hf;
    start_write <= 1'b1;
    @(posedge clk);
    start_write <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      check("busy_write", 32'(1'b1), 32'(busy_write));
    end while (!done_write && lat < 16);
    check("write latency", latency, lat);
    err = error;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data, output logic err);
    int lat;
    @(posedge clk);
    rd_addr    <= addr;
    start_read <= 1'b1;
    @(posedge clk);
    start_read <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      check("busy_read", 32'(1'b1), 32'(busy_read));
    end while (!done_read && lat < 16);
    check("read latency", latency, lat);
    data = rd_data;
    err  = error;
  endtask

  task automatic read_check(input axil_addr_t addr, input string name);
    reg_resp_t  exp;
    axil_data_t data;
    logic       err;
    exp = expect_reg(addr, model);
    axil_read(addr, data, err);
    check({name, " rd_data"}, exp.data, data);
    check({name, " error"}, 32'(exp.err), 32'(err));
    if (!exp.err && addr[3:0] == reg_rx_fifo) model.rx_valid = 1'b0;
    if (!exp.err && addr[3:0] == reg_stat) model.overrun = 1'b0;
  endtask

  task automatic write_check(input axil_addr_t addr, input axil_data_t data, input string name);
    reg_resp_t exp;
    logic      err;
    exp = expect_reg(addr, model);
    axil_write(addr, data, err);
    check({name, " error"}, 32'(exp.err), 32'(err));
    if (!exp.err && addr[3:0] == reg_tx_fifo) model.tx_idle = 1'b0;
    if (!exp.err && addr[3:0] == reg_ctrl && data[ctrl_rst_rx]) model.rx_valid = 1'b0;
  endtask

  // poll status until bit_idx is set, then check the frame and the whole status word
  task automatic poll_stat(input int bit_idx, input uart_byte_t sent);
    axil_data_t stat;
    logic       err;
    reg_resp_t  exp;
    uart_byte_t seen;
    do begin
      axil_read(stat_addr, stat, err);
    end while (!stat[bit_idx]);
    while (tx_seen.size() == 0) @(negedge clk);
    seen = tx_seen.pop_front();
    check("tx frame byte", 32'(sent), 32'(seen));
    // loopback byte lands before the stop bit ends
    model.tx_idle = 1'b1;
    if (model.rx_valid) begin
      model.overrun = 1'b1;
    end else begin
      model.rx_valid = 1'b1;
      model.rx_byte  = sent;
    end
    exp = expect_reg(stat_addr, model);
    check("stat rd_data", exp.data, stat);
    check("stat error", 32'(exp.err), 32'(err));
    model.overrun = 1'b0;
  endtask

  // decodes 8N1 frames on the tx pin at bit centers
  initial begin : tx_monitor
    uart_byte_t data;
    wait (arst_n === 1'b1);
    forever begin
      @(negedge serial_line);
      repeat (clks_per_bit / 2) @(posedge clk);
      @(negedge clk);
      check("tx start bit", 32'(1'b0), 32'(serial_line));
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        data[i] = serial_line;  // lsb first
      end
      repeat (clks_per_bit) @(negedge clk);
      check("tx stop bit", 32'(1'b1), 32'(serial_line));
      tx_seen.push_back(data);
    end
  end

  initial begin
    clk         = 1'b0;
    arst_n      <= 1'b0;
    start_read  <= 1'b0;
    start_write <= 1'b0;
    wr_req      <= '0;
    rd_addr     <= '0;
    model         = '0;
    model.tx_idle = 1'b1;
    seed_val = $urandom(32'hdb6e_dc8f);
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    read_check(stat_addr, "stat after reset");  // only tx_empty
    write_check(ctrl_addr, 32'h0, "ctrl idle write");

    // single frame and loopback
    byte_a = uart_byte_t'($urandom);
    write_check(tx_addr, {24'h0, byte_a}, "tx write");
    poll_stat(stat_rx_valid, byte_a);
    read_check(rx_addr, "rx read");
    read_check(stat_addr, "stat after rx read");

    // second byte arrives while the first is still held
    byte_b = uart_byte_t'($urandom);
    byte_c = uart_byte_t'($urandom);
    write_check(tx_addr, {24'h0, byte_b}, "tx write first");
    poll_stat(stat_rx_valid, byte_b);
    write_check(tx_addr, {24'h0, byte_c}, "tx write second");
    poll_stat(stat_tx_empty, byte_c);
    read_check(rx_addr, "rx read after overrun");
    read_check(stat_addr, "stat after overrun");

    read_check(32'h0000_0010, "bad read");
    write_check(32'h0000_0104, 32'h0, "bad write");

    // ctrl flush of a held byte
    byte_a = uart_byte_t'($urandom);
    write_check(tx_addr, {24'h0, byte_a}, "tx write flush");
    poll_stat(stat_rx_valid, byte_a);
    write_check(ctrl_addr, 32'h1 << ctrl_rst_rx, "ctrl rx flush");
    read_check(stat_addr, "stat after flush");

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
soc_pkg.sv
axil_master.sv
uart_lite_regs.sv
uart_tx.sv
uart_rx.sv
soc_periph_top.sv
soc_periph_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module soc_periph_tb

out=$(./obj_dir/Vsoc_periph_tb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
